/* common/notePkg.sv */
`default_nettype none

package notePkg;

	//////////////////////////////////////////////////////////////////////
	// Coordinate and colour types
	//////////////////////////////////////////////////////////////////////

	// Note position, wraps modulo 1024
	typedef logic [9:0] noteCoord;

	// Queried pixel position
	typedef logic [7:0] pixelXCoord;
	typedef logic [6:0] pixelYCoord;

	// Number from the song sequencer, 1 to 23 valid
	typedef logic [5:0] noteNumber;

	// RGB
	typedef logic [2:0] pixelColor;

	//////////////////////////////////////////////////////////////////////
	// Note geometry
	//////////////////////////////////////////////////////////////////////

	// Note n sits at n times the spacing
	localparam int noteSpacing = 10;

	// End minus start, so a box is 3x3 pixels
	localparam int noteWidth = 2;
	localparam int noteHeight = 2;

	localparam pixelColor noteColor = 3'b011;
	localparam pixelColor backgroundColor = 3'b000;

endpackage

`default_nettype wire

/* design/noteCommandDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module noteCommandDecoder
	import notePkg::*;
#(
	parameter int noteCount = 23
)
(
	input wire noteNumber numeroNota,
	input wire noteCoord posicionYNotaCancion1,
	input wire logic cuente,
	input wire logic movimientoIzquierda,
	input wire logic movimientoDerecha,
	output logic [noteCount-1:0] loadMask,
	output noteCoord loadX,
	output noteCoord loadY,
	output logic scrollLeft,
	output logic scrollRight
);

	logic numberValid;
	logic [noteCount-1:0] slotMask;

	//////////////////////////////////////////////////////////////////////
	// Note number decode
	//////////////////////////////////////////////////////////////////////

	assign numberValid = (numeroNota >= noteNumber'(1)) && (numeroNota <= noteNumber'(noteCount));

	// Note n lives at index n-1
	always_comb
	begin
		slotMask = '0;
		if (numberValid)
		begin
			slotMask = {{(noteCount-1){1'b0}}, 1'b1} << (numeroNota - noteNumber'(1));
		end
	end

	// Slot position fits in 10 bits for any 6-bit number
	assign loadX = noteCoord'(numeroNota) * noteCoord'(noteSpacing);
	assign loadY = posicionYNotaCancion1;

	//////////////////////////////////////////////////////////////////////
	// Command priority
	//////////////////////////////////////////////////////////////////////

	// Load wins, then left, then right
	always_comb
	begin
		loadMask = '0;
		scrollLeft = 1'b0;
		scrollRight = 1'b0;
		if (cuente)
		begin
			// Bad number swallows the strobe and blocks any scroll
			loadMask = slotMask;
		end
		else if (movimientoIzquierda)
		begin
			scrollLeft = 1'b1;
		end
		else if (movimientoDerecha)
		begin
			scrollRight = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/objetoNotas.sv */
`timescale 1ns/1ps
`default_nettype none

module objetoNotas
	import notePkg::*;
#(
	parameter int noteCount = 23,
	parameter int scrollStep = 10
)
(
	input wire logic clk,
	input wire logic reset,
	input wire noteNumber numeroNota,
	input wire noteCoord posicionYNotaCancion1,
	input wire logic cuente,
	input wire logic movimientoIzquierda,
	input wire logic movimientoDerecha,
	input wire pixelXCoord x,
	input wire pixelYCoord y,
	output pixelColor color,
	output logic notaActiva
);

	logic [noteCount-1:0] loadMask;
	noteCoord loadX;
	noteCoord loadY;
	logic scrollLeft;
	logic scrollRight;

	noteCoord noteXStart [noteCount];
	noteCoord noteYStart [noteCount];
	logic [noteCount-1:0] notePresent;

	//////////////////////////////////////////////////////////////////////
	// Command decode, note table, pixel query
	//////////////////////////////////////////////////////////////////////

	noteCommandDecoder #(
		.noteCount(noteCount)
	) decoder (
		.numeroNota(numeroNota),
		.posicionYNotaCancion1(posicionYNotaCancion1),
		.cuente(cuente),
		.movimientoIzquierda(movimientoIzquierda),
		.movimientoDerecha(movimientoDerecha),
		.loadMask(loadMask),
		.loadX(loadX),
		.loadY(loadY),
		.scrollLeft(scrollLeft),
		.scrollRight(scrollRight)
	);

	noteStore #(
		.noteCount(noteCount),
		.scrollStep(scrollStep)
	) store (
		.clk(clk),
		.reset(reset),
		.loadMask(loadMask),
		.loadX(loadX),
		.loadY(loadY),
		.scrollLeft(scrollLeft),
		.scrollRight(scrollRight),
		.noteXStart(noteXStart),
		.noteYStart(noteYStart),
		.notePresent(notePresent)
	);

	// Query result lands one cycle after x and y
	pixelRenderer #(
		.noteCount(noteCount)
	) renderer (
		.clk(clk),
		.reset(reset),
		.x(x),
		.y(y),
		.noteXStart(noteXStart),
		.noteYStart(noteYStart),
		.notePresent(notePresent),
		.color(color),
		.notaActiva(notaActiva)
	);

endmodule

`default_nettype wire

/* noteStore/noteStore.sv */
`timescale 1ns/1ps
`default_nettype none

module noteStore
	import notePkg::*;
#(
	parameter int noteCount = 23,
	parameter int scrollStep = 10
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [noteCount-1:0] loadMask,
	input wire noteCoord loadX,
	input wire noteCoord loadY,
	input wire logic scrollLeft,
	input wire logic scrollRight,
	output noteCoord noteXStart [noteCount],
	output noteCoord noteYStart [noteCount],
	output logic [noteCount-1:0] notePresent
);

	noteCoord xStart [noteCount];
	noteCoord yStart [noteCount];
	logic [noteCount-1:0] present;

	//////////////////////////////////////////////////////////////////////
	// Note table
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < noteCount; i++)
			begin
				xStart[i] <= '0;
				yStart[i] <= '0;
			end
			present <= '0;
		end
		else
		begin
			for (int i = 0; i < noteCount; i++)
			begin
				if (loadMask[i])
				begin
					xStart[i] <= loadX;
					yStart[i] <= loadY;
					present[i] <= 1'b1;
				end
				else if (scrollLeft)
				begin
					// Wraps past zero to the top of the range
					xStart[i] <= xStart[i] - noteCoord'(scrollStep);
				end
				else if (scrollRight)
				begin
					xStart[i] <= xStart[i] + noteCoord'(scrollStep);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < noteCount; i++)
		begin
			noteXStart[i] = xStart[i];
			noteYStart[i] = yStart[i];
		end
	end

	assign notePresent = present;

	// Decoder keeps loads and scrolls apart
	assertNoLoadWithScroll: assert property (
		@(posedge clk) disable iff (reset)
		!((|loadMask) && (scrollLeft || scrollRight))
	)
		else $error("load and scroll in the same cycle");

	assertSingleScroll: assert property (
		@(posedge clk) disable iff (reset)
		!(scrollLeft && scrollRight)
	)
		else $error("both scroll directions in the same cycle");

endmodule

`default_nettype wire

/* pixelRenderer/pixelRenderer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelRenderer
	import notePkg::*;
#(
	parameter int noteCount = 23
)
(
	input wire logic clk,
	input wire logic reset,
	input wire pixelXCoord x,
	input wire pixelYCoord y,
	input wire noteCoord noteXStart [noteCount],
	input wire noteCoord noteYStart [noteCount],
	input wire logic [noteCount-1:0] notePresent,
	output pixelColor color,
	output logic notaActiva
);

	noteCoord pixelX;
	noteCoord pixelY;
	noteCoord xEnd [noteCount];
	noteCoord yEnd [noteCount];
	logic [noteCount-1:0] noteHit;
	logic anyHit;

	//////////////////////////////////////////////////////////////////////
	// Hit test
	//////////////////////////////////////////////////////////////////////

	// Pixel coordinates are narrower than note coordinates
	assign pixelX = noteCoord'(x);
	assign pixelY = noteCoord'(y);

	always_comb
	begin
		for (int i = 0; i < noteCount; i++)
		begin
			xEnd[i] = noteXStart[i] + noteCoord'(noteWidth);
			yEnd[i] = noteYStart[i] + noteCoord'(noteHeight);
		end
	end

	// Box edges are inclusive on all four sides
	always_comb
	begin
		for (int i = 0; i < noteCount; i++)
		begin
			noteHit[i] = notePresent[i]
				&& (pixelX >= noteXStart[i]) && (pixelX <= xEnd[i])
				&& (pixelY >= noteYStart[i]) && (pixelY <= yEnd[i]);
		end
	end

	assign anyHit = |noteHit;

	//////////////////////////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			notaActiva <= 1'b0;
			color <= backgroundColor;
		end
		else
		begin
			notaActiva <= anyHit;
			if (anyHit)
			begin
				color <= noteColor;
			end
			else
			begin
				color <= backgroundColor;
			end
		end
	end

endmodule

`default_nettype wire

/* project.f */
common/notePkg.sv
design/noteCommandDecoder.sv
noteStore/noteStore.sv
pixelRenderer/pixelRenderer.sv
design/objetoNotas.sv
verification/objetoNotasTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module objetoNotasTb -f project.f -o simv \
	> build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
if grep -q "TB FAILED" sim.log
then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"
exit 0

/* verification/objetoNotasTb.sv */
`timescale 1ns/1ps
`default_nettype none

module objetoNotasTb;

	localparam int noteCount = 23;
	localparam int scrollStep = 10;
	localparam int slotSpacing = 10;
	localparam int boxSize = 2;
	localparam logic [2:0] hitColor = 3'b011;
	localparam logic [2:0] missColor = 3'b000;
	localparam int resetTimeout = 10;
	localparam int doneTimeout = 5000;

	localparam logic [2:0] opLoad = 3'd0;
	localparam logic [2:0] opLeft = 3'd1;
	localparam logic [2:0] opRight = 3'd2;
	localparam logic [2:0] opLoadScroll = 3'd3;
	localparam logic [2:0] opBothScroll = 3'd4;
	localparam logic [2:0] opProbe = 3'd5;

	// useModel selects the reference model over expectHit
	typedef struct packed {
		logic [2:0] op;
		logic [5:0] number;
		logic [9:0] yPos;
		logic [7:0] probeX;
		logic [6:0] probeY;
		logic useModel;
		logic expectHit;
	} tableRow;

	logic clk;
	logic reset;
	logic [5:0] numeroNota;
	logic [9:0] posicionYNotaCancion1;
	logic cuente;
	logic movimientoIzquierda;
	logic movimientoDerecha;
	logic [7:0] x;
	logic [6:0] y;
	logic [2:0] color;
	logic notaActiva;

	tableRow rows [$];
	logic [9:0] modelX [1:noteCount];
	logic [9:0] modelY [1:noteCount];
	logic modelPresent [1:noteCount];
	int errorCount = 0;
	int checkCount = 0;
	logic tableDone;

	objetoNotas #(
		.noteCount(noteCount),
		.scrollStep(scrollStep)
	) UUT (
		.clk(clk),
		.reset(reset),
		.numeroNota(numeroNota),
		.posicionYNotaCancion1(posicionYNotaCancion1),
		.cuente(cuente),
		.movimientoIzquierda(movimientoIzquierda),
		.movimientoDerecha(movimientoDerecha),
		.x(x),
		.y(y),
		.color(color),
		.notaActiva(notaActiva)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	task automatic updateModel(input tableRow row);
		int n;
		n = int'(row.number);
		if (row.op == opLoad || row.op == opLoadScroll)
		begin
			if (n >= 1 && n <= noteCount)
			begin
				modelX[n] = 10'(slotSpacing * n);
				modelY[n] = row.yPos;
				modelPresent[n] = 1'b1;
			end
		end
		else if (row.op == opLeft || row.op == opBothScroll)
		begin
			for (int i = 1; i <= noteCount; i++)
			begin
				modelX[i] = modelX[i] - 10'(scrollStep);
			end
		end
		else if (row.op == opRight)
		begin
			for (int i = 1; i <= noteCount; i++)
			begin
				modelX[i] = modelX[i] + 10'(scrollStep);
			end
		end
	endtask

	// Inclusive box edges, 10-bit wrap
	function automatic logic modelHit(input logic [7:0] px, input logic [6:0] py);
		logic hit;
		logic [9:0] wideX;
		logic [9:0] wideY;
		hit = 1'b0;
		wideX = {2'b00, px};
		wideY = {3'b000, py};
		for (int n = 1; n <= noteCount; n++)
		begin
			if (modelPresent[n]
				&& wideX >= modelX[n] && wideX <= modelX[n] + 10'(boxSize)
				&& wideY >= modelY[n] && wideY <= modelY[n] + 10'(boxSize))
			begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Table construction
	//////////////////////////////////////////////////////////////////////

	task automatic addCommand(input logic [2:0] op, input int number, input int yPos);
		rows.push_back({op, 6'(number), 10'(yPos), 8'd0, 7'd0, 1'b0, 1'b0});
	endtask

	task automatic probeAt(input int px, input int py, input logic expectHit);
		rows.push_back({opProbe, 6'd0, 10'd0, 8'(px), 7'(py), 1'b0, expectHit});
	endtask

	task automatic probeModel(input int px, input int py);
		rows.push_back({opProbe, 6'd0, 10'd0, 8'(px), 7'(py), 1'b1, 1'b0});
	endtask

	// Four corners hit, one pixel past each edge misses
	task automatic checkBox(input int bx, input int by);
		probeAt(bx, by, 1'b1);
		probeAt(bx + boxSize, by, 1'b1);
		probeAt(bx, by + boxSize, 1'b1);
		probeAt(bx + boxSize, by + boxSize, 1'b1);
		probeAt(bx - 1, by, 1'b0);
		probeAt(bx + boxSize + 1, by + boxSize, 1'b0);
		probeAt(bx, by - 1, 1'b0);
		probeAt(bx + boxSize, by + boxSize + 1, 1'b0);
	endtask

	task automatic checkGone(input int bx, input int by);
		probeAt(bx, by, 1'b0);
		probeAt(bx + boxSize, by + boxSize, 1'b0);
	endtask

	task automatic probeNear(input int bx, input int by, input int count);
		for (int i = 0; i < count; i++)
		begin
			probeModel(bx - 1 + int'($urandom % 5), by - 1 + int'($urandom % 5));
		end
	endtask

	task automatic buildTable();
		for (int i = 0; i < 8; i++)
		begin
			probeAt(int'($urandom % 256), int'($urandom % 128), 1'b0);
		end
		addCommand(opLoad, 3, 20);
		addCommand(opLoad, 7, 50);
		addCommand(opLoad, 23, 100);
		checkBox(30, 20);
		checkBox(70, 50);
		checkBox(230, 100);
		probeNear(30, 20, 6);
		probeNear(230, 100, 4);
		addCommand(opLeft, 0, 0);
		checkGone(30, 20);
		checkBox(20, 20);
		checkBox(60, 50);
		checkBox(220, 100);
		addCommand(opRight, 0, 0);
		checkGone(20, 20);
		checkBox(30, 20);
		checkBox(70, 50);
		// Load beats scroll, both levels scroll left
		addCommand(opLoadScroll, 5, 40);
		checkBox(50, 40);
		checkBox(30, 20);
		addCommand(opBothScroll, 0, 0);
		checkBox(20, 20);
		checkBox(40, 40);
		checkBox(60, 50);
		checkGone(50, 40);
		addCommand(opLoad, 0, 60);
		for (int i = 0; i < 3; i++)
		begin
			addCommand(opLoad, 24 + int'($urandom % 40), int'($urandom % 120));
		end
		checkGone(0, 60);
		checkBox(20, 20);
		checkBox(40, 40);
		probeNear(40, 40, 6);
		// Reload takes the slot position again
		addCommand(opLoad, 3, 80);
		checkGone(20, 20);
		checkBox(30, 80);
		probeNear(30, 80, 6);
		probeNear(60, 50, 6);
		for (int i = 0; i < 16; i++)
		begin
			probeModel(int'($urandom % 256), int'($urandom % 128));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Drive and check
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
		end
	endtask

	task automatic applyRow(input tableRow row);
		logic expectHit;
		@(posedge clk);
		numeroNota <= row.number;
		posicionYNotaCancion1 <= row.yPos;
		x <= row.probeX;
		y <= row.probeY;
		cuente <= (row.op == opLoad) || (row.op == opLoadScroll);
		movimientoIzquierda <= (row.op == opLeft) || (row.op == opLoadScroll)
			|| (row.op == opBothScroll);
		movimientoDerecha <= (row.op == opRight) || (row.op == opBothScroll);
		@(posedge clk);
		cuente <= 1'b0;
		movimientoIzquierda <= 1'b0;
		movimientoDerecha <= 1'b0;
		updateModel(row);
		if (row.op == opProbe)
		begin
			// Result registered at the edge just passed
			@(negedge clk);
			expectHit = row.useModel ? modelHit(row.probeX, row.probeY) : row.expectHit;
			checkValue(32'(notaActiva), 32'(expectHit),
				$sformatf("notaActiva at pixel (%0d,%0d)", row.probeX, row.probeY));
			checkValue(32'(color), expectHit ? 32'(hitColor) : 32'(missColor),
				$sformatf("color at pixel (%0d,%0d)", row.probeX, row.probeY));
		end
	endtask

	initial
	begin : stimulus
		int waitCycles;
		void'($urandom(27841));
		reset = 1'b1;
		numeroNota = '0;
		posicionYNotaCancion1 = '0;
		cuente = 1'b0;
		movimientoIzquierda = 1'b0;
		movimientoDerecha = 1'b0;
		x = '0;
		y = '0;
		tableDone = 1'b0;
		for (int n = 1; n <= noteCount; n++)
		begin
			modelX[n] = '0;
			modelY[n] = '0;
			modelPresent[n] = 1'b0;
		end
		buildTable();
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clk);
		end
		reset <= 1'b0;
		waitCycles = 0;
		while (reset !== 1'b0 && waitCycles < resetTimeout)
		begin
			@(posedge clk);
			waitCycles++;
		end
		if (reset !== 1'b0)
		begin
			$display("Reset was not released within %0d cycles", resetTimeout);
			$display("TB FAILED");
			$finish;
		end
		else
		begin
			for (int i = 0; i < rows.size(); i++)
			begin
				applyRow(rows[i]);
			end
			tableDone = 1'b1;
		end
	end

	initial
	begin : runControl
		int cycles;
		cycles = 0;
		while (tableDone !== 1'b1 && cycles < doneTimeout)
		begin
			@(posedge clk);
			cycles++;
		end
		if (tableDone !== 1'b1)
		begin
			$display("Stimulus table did not finish within %0d cycles", doneTimeout);
			$display("TB FAILED");
			$finish;
		end
		else
		begin
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			if (errorCount == 0)
			begin
				$display("TB PASSED");
			end
			else
			begin
				$display("TB FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
